// ==== bench/sample_streamer_chk.sv ====
// Stream and AXI4-Lite handshake assertions bound to the sample streamer top
`timescale 1ns/1ps
`default_nettype none
`include "stream_settings.svh"

module sample_streamer_chk (
  input logic                      clk,
  input logic                      rst,
  input logic [`STREAM_DATA_W-1:0] i_m_tdata,
  input logic                      i_m_tvalid,
  input logic                      i_m_tready,
  input logic                      i_m_tlast,
  input logic                      i_bvalid,
  input logic                      i_bready,
  input logic                      i_rvalid,
  input logic                      i_rready
);

  // ---------------------------------------------------------------------------
  // Packet output stream
  // ---------------------------------------------------------------------------

  // A beat on offer stays on offer until the sink takes it
  a_m_valid_hold: assert property (@(posedge clk) disable iff (rst)
    i_m_tvalid && !i_m_tready |=> i_m_tvalid)
    else $error("output tvalid fell before tready");

  // Header and payload words must not change while stalled
  a_m_beat_stable: assert property (@(posedge clk) disable iff (rst)
    i_m_tvalid && !i_m_tready |=> $stable(i_m_tdata) && $stable(i_m_tlast))
    else $error("output tdata or tlast changed during a stall");

  // ---------------------------------------------------------------------------
  // AXI4-Lite responses
  // ---------------------------------------------------------------------------

  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    i_bvalid && !i_bready |=> i_bvalid)
    else $error("BVALID fell before BREADY");

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    i_rvalid && !i_rready |=> i_rvalid)
    else $error("RVALID fell before RREADY");

endmodule

bind sample_streamer sample_streamer_chk u_chk (
  .clk        (clk),
  .rst        (rst),
  .i_m_tdata  (o_m_tdata),
  .i_m_tvalid (o_m_tvalid),
  .i_m_tready (i_m_tready),
  .i_m_tlast  (o_m_tlast),
  .i_bvalid   (o_bvalid),
  .i_bready   (i_bready),
  .i_rvalid   (o_rvalid),
  .i_rready   (i_rready)
);

`default_nettype wire

// ==== bench/sample_streamer_tb.sv ====
// Testbench with register, packet, size change, pause and back-pressure tests
`timescale 1ns/1ps
`default_nettype none
`include "stream_settings.svh"

module sample_streamer_tb;

  import stream_pkg::*;

  // Samples that the tests pass, with margin for the header beats and stalls
  localparam int TOTAL_SAMPLES  = 3 * 8 + 3 * 8 + 4 * 8 + 2 * 8 + 20 * 5;
  localparam int TIMEOUT_CYCLES = 8 * TOTAL_SAMPLES + 2000;

  logic clk;
  logic rst;

  logic [REG_ADDR_W-1:0]       i_awaddr;
  logic                        i_awvalid;
  logic                        o_awready;
  logic [`STREAM_DATA_W-1:0]   i_wdata;
  logic [`STREAM_DATA_W/8-1:0] i_wstrb;
  logic                        i_wvalid;
  logic                        o_wready;
  logic [1:0]                  o_bresp;
  logic                        o_bvalid;
  logic                        i_bready;
  logic [REG_ADDR_W-1:0]       i_araddr;
  logic                        i_arvalid;
  logic                        o_arready;
  logic [`STREAM_DATA_W-1:0]   o_rdata;
  logic [1:0]                  o_rresp;
  logic                        o_rvalid;
  logic                        i_rready;
  logic [`STREAM_DATA_W-1:0]   i_s_tdata;
  logic                        i_s_tvalid;
  logic                        o_s_tready;
  logic [`STREAM_DATA_W-1:0]   o_m_tdata;
  logic                        o_m_tvalid;
  logic                        i_m_tready;
  logic                        o_m_tlast;

  // ---------------------------------------------------------------------------
  // Test control and reference model state
  // ---------------------------------------------------------------------------
  string  test_name = "reset";
  logic   src_en;
  logic   sink_random;
  integer seed = 32;
  int     cycle_count = 0;

  // Shadow of the SIZE register, updated on the edge where the write lands
  logic [`STREAM_SIZE_W-1:0] model_size = `STREAM_DEFAULT_SIZE;
  logic [`STREAM_SIZE_W-1:0] exp_len = `STREAM_DEFAULT_SIZE;
  logic [`STREAM_SIZE_W-1:0] cur_len = '0;
  logic [`STREAM_SIZE_W-1:0] last_len = '0;
  logic [SEQ_W-1:0]          exp_seq = '0;
  logic [`STREAM_DATA_W-1:0] exp_sample = '0;
  logic                      expect_hdr = 1'b1;
  int                        pay_idx = 0;
  int                        hdr_count = 0;
  int                        pkt_done = 0;

  sample_streamer uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1, "watchdog stopped the run");
    end
  end

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // ---------------------------------------------------------------------------
  // Stream source, sink and monitor
  // ---------------------------------------------------------------------------

  // Incrementing count, held until accepted
  always @(posedge clk) begin
    if (rst) begin
      i_s_tvalid <= 1'b0;
      i_s_tdata  <= '0;
    end else begin
      if (i_s_tvalid && o_s_tready) begin
        i_s_tdata <= i_s_tdata + 1;
      end
      if (!i_s_tvalid || o_s_tready) begin
        i_s_tvalid <= src_en;
      end
    end
  end

  always @(posedge clk) begin : sink
    logic [31:0] rnd;
    if (sink_random) begin
      rnd = $random(seed);
      i_m_tready <= rnd[0];
    end else begin
      i_m_tready <= 1'b1;
    end
  end

  // Size is taken at each tlast and followed while nothing waits at the output
  always @(posedge clk) begin : monitor
    stream_word_u word;
    logic         last_exp;
    if (!rst) begin
      if (o_m_tvalid && i_m_tready) begin
        if (expect_hdr) begin
          word.raw = o_m_tdata;
          compare("header sequence", exp_seq, word.hdr.hdr_seq);
          compare("header length", exp_len, word.hdr.hdr_len);
          compare("header tlast", 1'b0, o_m_tlast);
          expect_hdr = 1'b0;
          pay_idx    = 0;
          cur_len    = exp_len;
          hdr_count++;
        end else begin
          last_exp = (pay_idx + 1 == int'(cur_len));
          compare("payload sample", exp_sample, o_m_tdata);
          compare("payload tlast", last_exp, o_m_tlast);
          exp_sample = exp_sample + 1;
          pay_idx++;
          if (last_exp) begin
            expect_hdr = 1'b1;
            exp_seq    = exp_seq + 1'b1;
            exp_len    = model_size;
            last_len   = cur_len;
            pkt_done++;
          end
        end
      end else if (expect_hdr && !o_m_tvalid) begin
        exp_len = model_size;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // AXI4-Lite access
  // ---------------------------------------------------------------------------

  // The response ready comes a cycle late, so each response waits for it
  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    i_awaddr  <= addr;
    i_awvalid <= 1'b1;
    i_wdata   <= data;
    i_wstrb   <= '1;
    i_wvalid  <= 1'b1;
    i_bready  <= 1'b0;
    @(posedge clk);
    while (!(o_awready && o_wready)) @(posedge clk);
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    if (addr == REG_SIZE) begin
      model_size <= data[`STREAM_SIZE_W-1:0];
    end
    @(posedge clk);
    while (!o_bvalid) @(posedge clk);
    compare("write response", 2'b00, o_bresp);
    @(posedge clk);
    i_bready <= 1'b1;
    @(posedge clk);
    i_bready <= 1'b0;
  endtask

  task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    i_araddr  <= addr;
    i_arvalid <= 1'b1;
    i_rready  <= 1'b0;
    @(posedge clk);
    while (!o_arready) @(posedge clk);
    i_arvalid <= 1'b0;
    @(posedge clk);
    while (!o_rvalid) @(posedge clk);
    data = o_rdata;
    compare("read response", 2'b00, o_rresp);
    @(posedge clk);
    i_rready <= 1'b1;
    @(posedge clk);
    i_rready <= 1'b0;
  endtask

  // ---------------------------------------------------------------------------
  // Directed tests
  // ---------------------------------------------------------------------------
  task automatic register_access();
    logic [31:0] rd;
    test_name = "register_access";
    read_reg(REG_SIZE, rd);
    compare("SIZE after reset", `STREAM_DEFAULT_SIZE, rd);
    read_reg(REG_STATUS, rd);
    compare("STATUS after reset", 0, rd);
    read_reg(REG_CTRL, rd);
    compare("CTRL after reset", 0, rd);
    write_reg(REG_SIZE, 32'h10);
    read_reg(REG_SIZE, rd);
    compare("SIZE readback", 32'h10, rd);
    write_reg(REG_SIZE, 8);
    read_reg(REG_SIZE, rd);
    compare("SIZE restored", 8, rd);
    write_reg(REG_CTRL, 1);
    read_reg(REG_CTRL, rd);
    compare("CTRL set", 1, rd);
    write_reg(REG_CTRL, 0);
    read_reg(REG_CTRL, rd);
    compare("CTRL cleared", 0, rd);
    read_reg(4'hC, rd);
    compare("unmapped read", 0, rd);
  endtask

  task automatic three_packets();
    int i;
    test_name = "three_packets";
    src_en <= 1'b1;
    write_reg(REG_SIZE, 8);
    write_reg(REG_CTRL, 1);
    for (i = 1; i <= 3; i++) begin
      wait (pkt_done >= i);
      compare("packet length", 8, last_len);
    end
  endtask

  task automatic size_change();
    int start;
    test_name = "size_change";
    wait (!expect_hdr && cur_len == 8 && pay_idx == 2);
    start = pkt_done;
    write_reg(REG_SIZE, 3);
    wait (pkt_done >= start + 1);
    compare("length of packet in flight", 8, last_len);
    wait (pkt_done >= start + 2);
    compare("first length after change", 3, last_len);
    wait (pkt_done >= start + 3);
    compare("second length after change", 3, last_len);
    write_reg(REG_SIZE, 1);
    wait (last_len == 1);
    start = pkt_done;
    wait (pkt_done >= start + 1);
    compare("single word packet length", 1, last_len);
  endtask

  // Disabled mid packet, so the packet must finish and nothing may follow
  task automatic pause_resume();
    int          hdrs;
    logic [31:0] rd;
    test_name = "pause_resume";
    write_reg(REG_SIZE, 8);
    wait (!expect_hdr && cur_len == 8 && pay_idx == 2);
    hdrs = hdr_count;
    write_reg(REG_CTRL, 0);
    wait (expect_hdr);
    repeat (20) @(posedge clk);
    compare("headers after disable", hdrs, hdr_count);
    compare("output valid while disabled", 1'b0, o_m_tvalid);
    read_reg(REG_STATUS, rd);
    compare("STATUS packet count", hdr_count, rd);
    write_reg(REG_CTRL, 1);
    hdrs = pkt_done;
    wait (pkt_done >= hdrs + 2);
  endtask

  task automatic random_backpressure();
    int start;
    int n;
    test_name = "random_backpressure";
    write_reg(REG_SIZE, 5);
    start = pkt_done;
    wait (pkt_done >= start + 2);
    sink_random <= 1'b1;
    start = pkt_done;
    for (n = 1; n <= 20; n++) begin
      wait (pkt_done >= start + n);
      compare("length under back-pressure", 5, last_len);
    end
    sink_random <= 1'b0;
  endtask

  // Stops the stream and gives the verdict
  task automatic finish_run();
    logic [31:0] rd;
    test_name = "finish_run";
    write_reg(REG_CTRL, 0);
    repeat (40) @(posedge clk);
    read_reg(REG_STATUS, rd);
    compare("final STATUS", pkt_done, rd);
    if (expect_hdr && hdr_count == pkt_done && !o_m_tvalid) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Stream did not stop at a packet boundary after disable");
      $display("Test FAILED");
      $fatal(1, "final idle check failed");
    end
  endtask

  initial begin
    rst         = 1'b1;
    src_en      = 1'b0;
    sink_random = 1'b0;
    i_awaddr    = '0;
    i_awvalid   = 1'b0;
    i_wdata     = '0;
    i_wstrb     = '0;
    i_wvalid    = 1'b0;
    i_bready    = 1'b0;
    i_araddr    = '0;
    i_arvalid   = 1'b0;
    i_rready    = 1'b0;
    i_s_tdata   = '0;
    i_s_tvalid  = 1'b0;
    i_m_tready  = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    register_access();
    three_packets();
    size_change();
    pause_resume();
    random_backpressure();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
rtl/stream_pkg.sv
rtl/stream_ctrl_regs.sv
rtl/axis_packetize.sv
rtl/pkt_hdr_insert.sv
rtl/sample_streamer.sv
bench/sample_streamer_chk.sv
bench/sample_streamer_tb.sv

// ==== include/stream_settings.svh ====
// Width, packet size and flush mode macros for the sample streamer
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Data path
// ---------------------------------------------------------------------------

// Width of one input sample and of one output word
`define STREAM_DATA_W 32

// Width of the packet size field, which also limits the largest packet
`define STREAM_SIZE_W 16

// ---------------------------------------------------------------------------
// Packetizer behavior
// ---------------------------------------------------------------------------

// Packet size loaded into the size register by reset
`define STREAM_DEFAULT_SIZE 8

// Zero stalls the input while the gate is closed, one drops it instead
`define STREAM_FLUSH 0

`endif

// ==== rtl/axis_packetize.sv ====
// Packetizer that cuts an untagged sample stream into packets behind a gate
`timescale 1ns/1ps
`default_nettype none
`include "stream_settings.svh"

module axis_packetize #(
  parameter int FLUSH = 0
) (
  input  logic                      clk,
  input  logic                      rst,

  // High requests that output stops at the next packet boundary
  input  logic                      i_gate,
  // Size used for the next packet that starts
  input  logic [`STREAM_SIZE_W-1:0] i_size,

  // Sample input without packet boundaries
  input  logic [`STREAM_DATA_W-1:0] i_tdata,
  input  logic                      i_tvalid,
  output logic                      o_i_tready,

  // Packet output, tuser carries the size of the current packet
  output logic [`STREAM_DATA_W-1:0] o_tdata,
  output logic                      o_tlast,
  output logic                      o_tvalid,
  input  logic                      i_o_tready,
  output logic [`STREAM_SIZE_W-1:0] o_tuser
);

  localparam int SIZE_W = `STREAM_SIZE_W;

  // Set while the next beat to leave is the first one of a packet
  logic              start_of_packet;
  // Number of beats of the current packet already transferred
  logic [SIZE_W-1:0] word_count;
  // Size sampled for the packet in flight
  logic [SIZE_W-1:0] current_size;
  // Index of the beat just before the last one
  logic [SIZE_W-1:0] last_m1;
  logic              size_is_one;

  // Output blocked when set, and at least one beat of a packet has gone out
  logic gating;
  logic mid_packet;

  logic out_xfer;
  logic boundary_ok;

  assign out_xfer    = o_tvalid && i_o_tready;
  assign last_m1     = current_size - SIZE_W'(2);
  assign size_is_one = (i_size == SIZE_W'(1));

  // ---------------------------------------------------------------------------
  // Packet size and tlast generation
  // ---------------------------------------------------------------------------

  assign o_tuser = current_size;

  // Tlast is registered, so it is already valid when the last beat appears.
  // The size is only sampled when no beat is on the output, which keeps
  // tuser steady for the whole packet, the pending first beat included
  always_ff @(posedge clk) begin
    if (rst) begin
      start_of_packet <= 1'b1;
      word_count      <= '0;
      current_size    <= SIZE_W'(`STREAM_DEFAULT_SIZE);
      o_tlast         <= (`STREAM_DEFAULT_SIZE == 1);
    end else if (gating) begin
      // Output is blocked so get ready for a fresh packet
      start_of_packet <= 1'b1;
      word_count      <= '0;
      current_size    <= i_size;
      o_tlast         <= size_is_one;
    end else if (out_xfer) begin
      if (o_tlast) begin
        // Last beat went out, the next beat opens a new packet
        start_of_packet <= 1'b1;
        word_count      <= '0;
        current_size    <= i_size;
        o_tlast         <= size_is_one;
      end else begin
        start_of_packet <= 1'b0;
        word_count      <= word_count + SIZE_W'(1);
        // Flag the following beat as the last one
        if (word_count == last_m1) begin
          o_tlast <= 1'b1;
        end
      end
    end else if (start_of_packet && !o_tvalid) begin
      // Idle between packets, so keep tracking the size input
      word_count   <= '0;
      current_size <= i_size;
      o_tlast      <= size_is_one;
    end
  end

  // ---------------------------------------------------------------------------
  // Handshake monitor and gate
  // ---------------------------------------------------------------------------

  // The gate may close only where no beat is left hanging: with nothing on
  // the output between packets, or on the tlast transfer itself
  assign boundary_ok = (!mid_packet && !o_tvalid) || (out_xfer && o_tlast);

  // Reset leaves the output gated, which gives the size one cycle to load
  always_ff @(posedge clk) begin
    if (rst) begin
      gating     <= 1'b1;
      mid_packet <= 1'b0;
    end else begin
      // The first beat of a packet does not count as mid packet
      if (out_xfer) begin
        mid_packet <= !o_tlast;
      end

      if (gating) begin
        // Opening is allowed at any time
        if (!i_gate) begin
          gating <= 1'b0;
        end
      end else if (boundary_ok) begin
        gating <= i_gate;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Data path
  // ---------------------------------------------------------------------------

  assign o_tdata  = i_tdata;
  assign o_tvalid = i_tvalid && !gating;

  // In flush mode a closed gate accepts and drops the input
  assign o_i_tready = (FLUSH != 0) ? (i_o_tready || gating) : (i_o_tready && !gating);

endmodule

`default_nettype wire

// ==== rtl/pkt_hdr_insert.sv ====
// Header inserter that puts a sequence and length word in front of each packet
`timescale 1ns/1ps
`default_nettype none
`include "stream_settings.svh"

module pkt_hdr_insert (
  input  logic                         clk,
  input  logic                         rst,

  // Packet input, tuser holds the length of the packet
  input  logic [`STREAM_DATA_W-1:0]    i_tdata,
  input  logic                         i_tvalid,
  input  logic                         i_tlast,
  input  logic [`STREAM_SIZE_W-1:0]    i_tuser,
  output logic                         o_i_tready,

  // Packet output with one header beat in front of the payload
  output logic [`STREAM_DATA_W-1:0]    o_tdata,
  output logic                         o_tvalid,
  output logic                         o_tlast,
  input  logic                         i_o_tready,

  // Number of packets whose last beat has been accepted
  output logic [stream_pkg::SEQ_W-1:0] o_pkt_count
);

  import stream_pkg::*;

  // ---------------------------------------------------------------------------
  // Packet state
  // ---------------------------------------------------------------------------

  localparam logic ST_HDR = 1'b0;
  localparam logic ST_PAY = 1'b1;

  logic             state;
  logic [SEQ_W-1:0] seq_cnt;
  stream_word_u     hdr_word;

  logic in_xfer;
  logic out_xfer;

  assign in_xfer  = i_tvalid && o_i_tready;
  assign out_xfer = o_tvalid && i_o_tready;

  // The header leaves while the first sample waits at the input.
  // Payload then flows until the input tlast is accepted
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_HDR;
    end else begin
      case (state)
        ST_HDR: begin
          if (out_xfer) begin
            state <= ST_PAY;
          end
        end
        default: begin
          if (in_xfer && i_tlast) begin
            state <= ST_HDR;
          end
        end
      endcase
    end
  end

  // Sequence number of the next header, wraps around at its full width
  always_ff @(posedge clk) begin
    if (rst) begin
      seq_cnt <= '0;
    end else if (state == ST_PAY && in_xfer && i_tlast) begin
      seq_cnt <= seq_cnt + SEQ_W'(1);
    end
  end

  assign o_pkt_count = seq_cnt;

  // ---------------------------------------------------------------------------
  // Header word and output mux
  // ---------------------------------------------------------------------------

  // The packetizer holds tuser steady while a beat waits, so the length
  // matches the packet that follows
  always_comb begin
    hdr_word.hdr.hdr_seq = seq_cnt;
    hdr_word.hdr.hdr_len = i_tuser;
  end

  // A pending first sample also stands for a pending header
  assign o_tvalid = i_tvalid;

  // Input is held back during the header beat
  assign o_i_tready = (state == ST_PAY) && i_o_tready;

  assign o_tdata = (state == ST_HDR) ? hdr_word.raw : i_tdata;

  // The header never ends a packet
  assign o_tlast = (state == ST_PAY) && i_tlast;

endmodule

`default_nettype wire

// ==== rtl/sample_streamer.sv ====
// Top level of the sample streamer with register block, packetizer and header
`timescale 1ns/1ps
`default_nettype none
`include "stream_settings.svh"

module sample_streamer (
  input  logic                              clk,
  input  logic                              rst,

  // AXI4-Lite control port
  input  logic [stream_pkg::REG_ADDR_W-1:0] i_awaddr,
  input  logic                              i_awvalid,
  output logic                              o_awready,
  input  logic [`STREAM_DATA_W-1:0]         i_wdata,
  input  logic [`STREAM_DATA_W/8-1:0]       i_wstrb,
  input  logic                              i_wvalid,
  output logic                              o_wready,
  output logic [1:0]                        o_bresp,
  output logic                              o_bvalid,
  input  logic                              i_bready,
  input  logic [stream_pkg::REG_ADDR_W-1:0] i_araddr,
  input  logic                              i_arvalid,
  output logic                              o_arready,
  output logic [`STREAM_DATA_W-1:0]         o_rdata,
  output logic [1:0]                        o_rresp,
  output logic                              o_rvalid,
  input  logic                              i_rready,

  // Sample input stream
  input  logic [`STREAM_DATA_W-1:0]         i_s_tdata,
  input  logic                              i_s_tvalid,
  output logic                              o_s_tready,

  // Packet output stream
  output logic [`STREAM_DATA_W-1:0]         o_m_tdata,
  output logic                              o_m_tvalid,
  input  logic                              i_m_tready,
  output logic                              o_m_tlast
);

  logic                         gate;
  logic [`STREAM_SIZE_W-1:0]    size;
  logic [stream_pkg::SEQ_W-1:0] pkt_count;

  // Packetizer to header inserter
  logic [`STREAM_DATA_W-1:0] pk_tdata;
  logic                      pk_tvalid;
  logic                      pk_tready;
  logic                      pk_tlast;
  logic [`STREAM_SIZE_W-1:0] pk_tuser;

  stream_ctrl_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .i_awaddr    (i_awaddr),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .o_bresp     (o_bresp),
    .o_bvalid    (o_bvalid),
    .i_bready    (i_bready),
    .i_araddr    (i_araddr),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .i_pkt_count (pkt_count),
    .o_gate      (gate),
    .o_size      (size)
  );

  // Samples are stalled, never dropped, while the gate is closed
  axis_packetize #(
    .FLUSH (`STREAM_FLUSH)
  ) u_packetize (
    .clk        (clk),
    .rst        (rst),
    .i_gate     (gate),
    .i_size     (size),
    .i_tdata    (i_s_tdata),
    .i_tvalid   (i_s_tvalid),
    .o_i_tready (o_s_tready),
    .o_tdata    (pk_tdata),
    .o_tlast    (pk_tlast),
    .o_tvalid   (pk_tvalid),
    .i_o_tready (pk_tready),
    .o_tuser    (pk_tuser)
  );

  pkt_hdr_insert u_hdr_insert (
    .clk         (clk),
    .rst         (rst),
    .i_tdata     (pk_tdata),
    .i_tvalid    (pk_tvalid),
    .i_tlast     (pk_tlast),
    .i_tuser     (pk_tuser),
    .o_i_tready  (pk_tready),
    .o_tdata     (o_m_tdata),
    .o_tvalid    (o_m_tvalid),
    .o_tlast     (o_m_tlast),
    .i_o_tready  (i_m_tready),
    .o_pkt_count (pkt_count)
  );

endmodule

`default_nettype wire

// ==== rtl/stream_ctrl_regs.sv ====
// AXI4-Lite slave with control, packet size and status registers
`timescale 1ns/1ps
`default_nettype none
`include "stream_settings.svh"

module stream_ctrl_regs (
  input  logic                              clk,
  input  logic                              rst,

  // Write address and write data channels
  input  logic [stream_pkg::REG_ADDR_W-1:0] i_awaddr,
  input  logic                              i_awvalid,
  output logic                              o_awready,
  input  logic [`STREAM_DATA_W-1:0]         i_wdata,
  input  logic [`STREAM_DATA_W/8-1:0]       i_wstrb,
  input  logic                              i_wvalid,
  output logic                              o_wready,

  // Write response channel
  output logic [1:0]                        o_bresp,
  output logic                              o_bvalid,
  input  logic                              i_bready,

  // Read address and read data channels
  input  logic [stream_pkg::REG_ADDR_W-1:0] i_araddr,
  input  logic                              i_arvalid,
  output logic                              o_arready,
  output logic [`STREAM_DATA_W-1:0]         o_rdata,
  output logic [1:0]                        o_rresp,
  output logic                              o_rvalid,
  input  logic                              i_rready,

  // Packet count from the header inserter
  input  logic [stream_pkg::SEQ_W-1:0]      i_pkt_count,

  // Controls for the packetizer
  output logic                              o_gate,
  output logic [`STREAM_SIZE_W-1:0]         o_size
);

  import stream_pkg::*;

  localparam int SIZE_W = `STREAM_SIZE_W;

  logic              ctrl_enable;
  logic [SIZE_W-1:0] size_reg;

  logic wr_ready;
  logic wr_start;
  logic wr_en;
  logic rd_start;
  logic rd_en;

  logic [`STREAM_DATA_W-1:0] rd_word;

  // ---------------------------------------------------------------------------
  // Write path
  // ---------------------------------------------------------------------------

  // Only one write is in flight, a new one waits for the response to clear
  assign wr_start = i_awvalid && i_wvalid && !wr_ready && !o_bvalid;
  assign wr_en    = wr_ready && i_awvalid && i_wvalid;

  // AW and W are accepted together on a single cycle pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ready <= 1'b0;
      o_bvalid <= 1'b0;
    end else begin
      wr_ready <= wr_start;
      if (wr_en) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  assign o_awready = wr_ready;
  assign o_wready  = wr_ready;

  // Every access completes with OKAY
  assign o_bresp = 2'b00;

  // Register updates honor the byte strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_enable <= 1'b0;
      size_reg    <= SIZE_W'(`STREAM_DEFAULT_SIZE);
    end else if (wr_en) begin
      if (i_awaddr == REG_CTRL && i_wstrb[0]) begin
        ctrl_enable <= i_wdata[0];
      end
      if (i_awaddr == REG_SIZE) begin
        for (int b = 0; b < SIZE_W / 8; b++) begin
          if (i_wstrb[b]) begin
            size_reg[b*8 +: 8] <= i_wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  // The packetizer is gated whenever streaming is disabled
  assign o_gate = !ctrl_enable;
  assign o_size = size_reg;

  // ---------------------------------------------------------------------------
  // Read path
  // ---------------------------------------------------------------------------

  assign rd_start = i_arvalid && !o_arready && !o_rvalid;
  assign rd_en    = o_arready && i_arvalid;

  // Unmapped offsets read as zero
  always_comb begin
    rd_word = '0;
    case (i_araddr)
      REG_CTRL:   rd_word[0]          = ctrl_enable;
      REG_SIZE:   rd_word[SIZE_W-1:0] = size_reg;
      REG_STATUS: rd_word[SEQ_W-1:0]  = i_pkt_count;
      default:    rd_word             = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
    end else begin
      o_arready <= rd_start;
      if (rd_en) begin
        o_rvalid <= 1'b1;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  // Read data is captured with the address handshake
  always_ff @(posedge clk) begin
    if (rd_en) begin
      o_rdata <= rd_word;
    end
  end

  assign o_rresp = 2'b00;

endmodule

`default_nettype wire

// ==== rtl/stream_pkg.sv ====
// Output word union and register map constants of the sample streamer
`default_nettype none
`include "stream_settings.svh"

package stream_pkg;

  // Width of the packet sequence number, which fills the upper header half
  localparam int SEQ_W = `STREAM_DATA_W - `STREAM_SIZE_W;

  // Width of the AXI4-Lite byte address
  localparam int REG_ADDR_W = 4;

  // ---------------------------------------------------------------------------
  // Register map
  // ---------------------------------------------------------------------------
  localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 4'h0;
  localparam logic [REG_ADDR_W-1:0] REG_SIZE   = 4'h4;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS = 4'h8;

  // One output stream word, seen either as a plain sample or as a header
  typedef union packed {
    logic [`STREAM_DATA_W-1:0] raw;
    struct packed {
      logic [SEQ_W-1:0]          hdr_seq;
      logic [`STREAM_SIZE_W-1:0] hdr_len;
    } hdr;
  } stream_word_u;

endpackage

`default_nettype wire
